//--- fetch_top.f
+incdir+include
hw/fetch_pkg.sv
hw/word_mem.sv
hw/mem_arbiter.sv
hw/data_port.sv
hw/icache_fetch.sv
hw/fetch_top.sv
testbench/tb_fetch_top.sv

//--- hw/data_port.sv
`timescale 1ns/10ps

module data_port (
  input  logic                 clk,
  input  logic                 rst,
  input  fetch_pkg::data_req_t data_req_i,
  output fetch_pkg::data_rsp_t data_rsp_o,
  output fetch_pkg::mem_req_t  mem_req_o,
  input  logic                 mem_grant_i,
  input  fetch_pkg::mem_rsp_t  mem_rsp_i
);

  fetch_pkg::data_req_t req_q;
  logic                 busy_q;
  logic                 pend_q;

  // held toward the arbiter until granted
  always_comb
  begin
    mem_req_o.valid = pend_q;
    mem_req_o.write = req_q.write;
    mem_req_o.addr  = req_q.addr;
    mem_req_o.wdata = req_q.wdata;
  end

  // writes come back with zero rdata from memory
  assign data_rsp_o.valid = busy_q && mem_rsp_i.valid;
  assign data_rsp_o.rdata = mem_rsp_i.rdata;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy_q <= 1'b0;
      pend_q <= 1'b0;
    end
    else
    begin
      if (data_req_i.valid && !busy_q)
      begin
        busy_q <= 1'b1;
        pend_q <= 1'b1;
      end
      else
      begin
        if (mem_grant_i)
        begin
          pend_q <= 1'b0;
        end
        if (mem_rsp_i.valid)
        begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (data_req_i.valid && !busy_q)
    begin
      req_q <= data_req_i;
    end
  end

endmodule

//--- hw/fetch_pkg.sv
`include "fetch_macros.svh"

package fetch_pkg;

  typedef logic [`FETCH_ADDR_W-1:0] addr_t;
  typedef logic [`FETCH_DATA_W-1:0] word_t;

  // tag is everything above index, word offset and byte offset
  typedef logic [`FETCH_ADDR_W-`IC_INDEX_W-`IC_OFFSET_W-3:0] ic_tag_t;
  typedef logic [`IC_INDEX_W-1:0] ic_index_t;

  typedef struct packed {
    logic  valid;
    addr_t pc;
  } fetch_req_t;

  typedef struct packed {
    logic  valid;
    addr_t pc;
    word_t inst;
  } fetch_rsp_t;

  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    word_t wdata;
  } data_req_t;

  typedef struct packed {
    logic  valid;
    word_t rdata;
  } data_rsp_t;

  // request as seen by the memory
  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    word_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic  valid;
    word_t rdata;
  } mem_rsp_t;

  typedef enum logic [1:0] {
    ic_idle,
    ic_refill_lo,
    ic_refill_hi
  } ic_state_e;

  typedef enum logic [1:0] {
    owner_none,
    owner_fetch,
    owner_data
  } arb_owner_e;

endpackage

//--- hw/fetch_top.sv
`timescale 1ns/10ps

module fetch_top (
  input  logic                  clk,
  input  logic                  rst,
  input  fetch_pkg::fetch_req_t fetch_req_i,
  output fetch_pkg::fetch_rsp_t fetch_rsp_o,
  input  fetch_pkg::data_req_t  data_req_i,
  output fetch_pkg::data_rsp_t  data_rsp_o
);

  fetch_pkg::mem_req_t ic_mem_req;
  fetch_pkg::mem_req_t dp_mem_req;
  fetch_pkg::mem_rsp_t ic_mem_rsp;
  fetch_pkg::mem_rsp_t dp_mem_rsp;
  fetch_pkg::mem_req_t mem_req;
  fetch_pkg::mem_rsp_t mem_rsp;
  logic                ic_grant;
  logic                dp_grant;

  icache_fetch icache_fetch_i (
    .clk         (clk),
    .rst         (rst),
    .fetch_req_i (fetch_req_i),
    .fetch_rsp_o (fetch_rsp_o),
    .mem_req_o   (ic_mem_req),
    .mem_grant_i (ic_grant),
    .mem_rsp_i   (ic_mem_rsp)
  );

  data_port data_port_i (
    .clk         (clk),
    .rst         (rst),
    .data_req_i  (data_req_i),
    .data_rsp_o  (data_rsp_o),
    .mem_req_o   (dp_mem_req),
    .mem_grant_i (dp_grant),
    .mem_rsp_i   (dp_mem_rsp)
  );

  mem_arbiter mem_arbiter_i (
    .clk           (clk),
    .rst           (rst),
    .fetch_req_i   (ic_mem_req),
    .data_req_i    (dp_mem_req),
    .fetch_grant_o (ic_grant),
    .data_grant_o  (dp_grant),
    .fetch_rsp_o   (ic_mem_rsp),
    .data_rsp_o    (dp_mem_rsp),
    .mem_req_o     (mem_req),
    .mem_rsp_i     (mem_rsp)
  );

  word_mem word_mem_i (
    .clk       (clk),
    .rst       (rst),
    .mem_req_i (mem_req),
    .mem_rsp_o (mem_rsp)
  );

endmodule

//--- hw/icache_fetch.sv
`timescale 1ns/10ps
`include "fetch_macros.svh"

module icache_fetch (
  input  logic                  clk,
  input  logic                  rst,
  input  fetch_pkg::fetch_req_t fetch_req_i,
  output fetch_pkg::fetch_rsp_t fetch_rsp_o,
  output fetch_pkg::mem_req_t   mem_req_o,
  input  logic                  mem_grant_i,
  input  fetch_pkg::mem_rsp_t   mem_rsp_i
);

  localparam int tag_lsb = `IC_INDEX_W + `IC_OFFSET_W + 2;

  fetch_pkg::ic_state_e state_q;
  fetch_pkg::addr_t     pc_q;
  logic                 lookup_q;
  logic                 wait_q;
  logic                 fill_done_q;
  logic [`IC_SETS-1:0]  valid_q;

  // line storage and tags
  fetch_pkg::word_t   line_q [`IC_SETS][`IC_LINE_WORDS];
  fetch_pkg::ic_tag_t tag_q  [`IC_SETS];

  fetch_pkg::ic_tag_t      pc_tag;
  fetch_pkg::ic_index_t    pc_idx;
  logic [`IC_OFFSET_W-1:0] pc_off;
  logic [`IC_OFFSET_W-1:0] refill_off;
  logic                    hit;
  logic                    miss;

  assign pc_tag = pc_q[`FETCH_ADDR_W-1:tag_lsb];
  assign pc_idx = pc_q[tag_lsb-1:`IC_OFFSET_W+2];
  assign pc_off = pc_q[`IC_OFFSET_W+1:2];

  // lookup happens the cycle after the request strobe
  assign hit = lookup_q && (state_q == fetch_pkg::ic_idle) && valid_q[pc_idx]
               && (tag_q[pc_idx] == pc_tag);
  assign miss = lookup_q && (state_q == fetch_pkg::ic_idle) && !hit;

  // low word first, then the high word of the line
  assign refill_off = (state_q == fetch_pkg::ic_refill_hi) ? {`IC_OFFSET_W{1'b1}} : '0;

  always_comb
  begin
    // request stays up until granted
    mem_req_o.valid = (state_q == fetch_pkg::ic_idle) ? miss : !wait_q;
    mem_req_o.write = 1'b0;
    mem_req_o.addr  = {pc_tag, pc_idx, refill_off, 2'b00};
    mem_req_o.wdata = '0;
  end

  always_comb
  begin
    fetch_rsp_o.valid = hit || fill_done_q;
    fetch_rsp_o.pc    = pc_q;
    fetch_rsp_o.inst  = line_q[pc_idx][pc_off];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q     <= fetch_pkg::ic_idle;
      lookup_q    <= 1'b0;
      wait_q      <= 1'b0;
      fill_done_q <= 1'b0;
      valid_q     <= '0;
    end
    else
    begin
      lookup_q    <= fetch_req_i.valid;
      fill_done_q <= 1'b0;
      case (state_q)
        fetch_pkg::ic_idle:
          if (miss)
          begin
            state_q <= fetch_pkg::ic_refill_lo;
            // arbiter may grant in the miss cycle already
            wait_q  <= mem_grant_i;
          end
        fetch_pkg::ic_refill_lo:
          if (mem_rsp_i.valid)
          begin
            state_q <= fetch_pkg::ic_refill_hi;
            wait_q  <= 1'b0;
          end
          else if (mem_grant_i)
          begin
            wait_q <= 1'b1;
          end
        fetch_pkg::ic_refill_hi:
          if (mem_rsp_i.valid)
          begin
            state_q         <= fetch_pkg::ic_idle;
            wait_q          <= 1'b0;
            valid_q[pc_idx] <= 1'b1;
            fill_done_q     <= 1'b1;
          end
          else if (mem_grant_i)
          begin
            wait_q <= 1'b1;
          end
        default:
          state_q <= fetch_pkg::ic_idle;
      endcase
      // fence.i drops every line, the answered one included
      if (fetch_rsp_o.valid && (fetch_rsp_o.inst == `FENCE_I_WORD))
      begin
        valid_q <= '0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (fetch_req_i.valid)
    begin
      pc_q <= fetch_req_i.pc;
    end
    if (mem_rsp_i.valid && (state_q != fetch_pkg::ic_idle))
    begin
      line_q[pc_idx][refill_off] <= mem_rsp_i.rdata;
      tag_q[pc_idx]              <= pc_tag;
    end
  end

endmodule

//--- hw/mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter (
  input  logic                clk,
  input  logic                rst,
  input  fetch_pkg::mem_req_t fetch_req_i,
  input  fetch_pkg::mem_req_t data_req_i,
  output logic                fetch_grant_o,
  output logic                data_grant_o,
  output fetch_pkg::mem_rsp_t fetch_rsp_o,
  output fetch_pkg::mem_rsp_t data_rsp_o,
  output fetch_pkg::mem_req_t mem_req_o,
  input  fetch_pkg::mem_rsp_t mem_rsp_i
);

  fetch_pkg::arb_owner_e owner_q;
  logic                  idle;

  // one transaction in flight at most
  assign idle = (owner_q == fetch_pkg::owner_none);

  // data port has priority
  assign data_grant_o  = idle && data_req_i.valid;
  assign fetch_grant_o = idle && fetch_req_i.valid && !data_req_i.valid;

  always_comb
  begin
    if (data_grant_o)
    begin
      mem_req_o = data_req_i;
    end
    else if (fetch_grant_o)
    begin
      mem_req_o = fetch_req_i;
    end
    else
    begin
      mem_req_o = '0;
    end
  end

  // response goes to the owner only
  assign fetch_rsp_o.valid = mem_rsp_i.valid && (owner_q == fetch_pkg::owner_fetch);
  assign fetch_rsp_o.rdata = mem_rsp_i.rdata;
  assign data_rsp_o.valid  = mem_rsp_i.valid && (owner_q == fetch_pkg::owner_data);
  assign data_rsp_o.rdata  = mem_rsp_i.rdata;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      owner_q <= fetch_pkg::owner_none;
    end
    else if (data_grant_o)
    begin
      owner_q <= fetch_pkg::owner_data;
    end
    else if (fetch_grant_o)
    begin
      owner_q <= fetch_pkg::owner_fetch;
    end
    else if (mem_rsp_i.valid)
    begin
      owner_q <= fetch_pkg::owner_none;
    end
  end

endmodule

//--- hw/word_mem.sv
`timescale 1ns/10ps
`include "fetch_macros.svh"

module word_mem (
  input  logic                clk,
  input  logic                rst,
  input  fetch_pkg::mem_req_t mem_req_i,
  output fetch_pkg::mem_rsp_t mem_rsp_o
);

  localparam int idx_w = $clog2(`MEM_WORDS);

  fetch_pkg::word_t         mem_q [`MEM_WORDS];
  logic [`MEM_LATENCY-1:0]  rd_valid_q;
  fetch_pkg::word_t         rd_data_q [`MEM_LATENCY];
  logic                     wr_ack_q;
  logic [idx_w-1:0]         word_idx;

  // word index, byte offset dropped
  assign word_idx = mem_req_i.addr[idx_w+1:2];

  assign mem_rsp_o.valid = rd_valid_q[`MEM_LATENCY-1] || wr_ack_q;
  assign mem_rsp_o.rdata = rd_valid_q[`MEM_LATENCY-1] ? rd_data_q[`MEM_LATENCY-1] : '0;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rd_valid_q <= '0;
      wr_ack_q   <= 1'b0;
    end
    else
    begin
      rd_valid_q <= {rd_valid_q[`MEM_LATENCY-2:0], mem_req_i.valid && !mem_req_i.write};
      wr_ack_q   <= mem_req_i.valid && mem_req_i.write;
    end
  end

  // read data pipeline and array write
  always_ff @(posedge clk)
  begin
    rd_data_q[0] <= mem_q[word_idx];
    for (int i = 1; i < `MEM_LATENCY; i++)
    begin
      rd_data_q[i] <= rd_data_q[i-1];
    end
    if (mem_req_i.valid && mem_req_i.write)
    begin
      mem_q[word_idx] <= mem_req_i.wdata;
    end
  end

endmodule

//--- include/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// address and data widths
`define FETCH_ADDR_W 32
`define FETCH_DATA_W 32

// l1 instruction cache geometry
`define IC_SETS       8
`define IC_INDEX_W    3
`define IC_LINE_WORDS 2
`define IC_OFFSET_W   1

// shared word memory
`define MEM_WORDS   1024
`define MEM_LATENCY 2

// fence.i encoding, invalidates the whole icache
`define FENCE_I_WORD 32'h0000100f

`endif

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and scan the log for the fail message
verilator --binary --timing --timescale 1ns/10ps --top-module tb_fetch_top \
  -f fetch_top.f --Mdir obj_dir -o sim_fetch_top || exit 1
./obj_dir/sim_fetch_top > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0

//--- testbench/tb_fetch_top.sv
`timescale 1ns/10ps
`include "fetch_macros.svh"

module tb_fetch_top;

  localparam int timeout_cycles = 50;
  localparam int tag_lsb = `IC_INDEX_W + `IC_OFFSET_W + 2;
  localparam int mem_idx_w = $clog2(`MEM_WORDS);

  localparam fetch_pkg::addr_t pc_a     = 32'h0000_0100;
  localparam fetch_pkg::addr_t pc_fence = 32'h0000_0158;
  localparam fetch_pkg::addr_t pc_b     = 32'h0000_0080;
  localparam fetch_pkg::addr_t pc_c     = 32'h0000_0280;
  localparam fetch_pkg::addr_t pc_e     = 32'h0000_01c0;
  localparam fetch_pkg::addr_t data_d   = 32'h0000_0300;

  logic                  clk;
  logic                  rst;
  fetch_pkg::fetch_req_t fetch_req;
  fetch_pkg::fetch_rsp_t fetch_rsp;
  fetch_pkg::data_req_t  data_req;
  fetch_pkg::data_rsp_t  data_rsp;

  // reference memory image and cache contents
  fetch_pkg::word_t     img [`MEM_WORDS];
  logic [`IC_SETS-1:0]  mdl_valid;
  fetch_pkg::ic_tag_t   mdl_tag [`IC_SETS];
  fetch_pkg::word_t     mdl_line [`IC_SETS][`IC_LINE_WORDS];

  logic [31:0] lcg_state;
  string       cur_test;
  int          test_errs;
  int          total_errs;
  int          tests_run;
  int          tests_failed;

  fetch_top dut_i (
    .clk         (clk),
    .rst         (rst),
    .fetch_req_i (fetch_req),
    .fetch_rsp_o (fetch_rsp),
    .data_req_i  (data_req),
    .data_rsp_o  (data_rsp)
  );

  always #50 clk = ~clk;

  function automatic fetch_pkg::word_t lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // random instruction, never the fence.i encoding
  function automatic fetch_pkg::word_t rand_inst();
    fetch_pkg::word_t w;
    w = lcg_next();
    while (w == `FENCE_I_WORD)
    begin
      w = lcg_next();
    end
    return w;
  endfunction

  function automatic logic [mem_idx_w-1:0] img_index(input fetch_pkg::addr_t a);
    return a[mem_idx_w+1:2];
  endfunction

  task automatic check_word(input string what, input fetch_pkg::word_t exp_val,
                            input fetch_pkg::word_t act_val);
    if (exp_val !== act_val)
    begin
      $display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp_val, act_val);
      test_errs++;
    end
  endtask

  task automatic check_addr(input string what, input fetch_pkg::addr_t exp_val,
                            input fetch_pkg::addr_t act_val);
    if (exp_val !== act_val)
    begin
      $display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp_val, act_val);
      test_errs++;
    end
  endtask

  task automatic check_cycles(input string what, input int exp_val, input int act_val);
    if (exp_val != act_val)
    begin
      $display("FAILED %s %s: expected %0d, actual %0d", cur_test, what, exp_val, act_val);
      test_errs++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    total_errs += test_errs;
    if (test_errs == 0)
    begin
      $display("test %s passed", cur_test);
    end
    else
    begin
      tests_failed++;
      $display("test %s failed with %0d errors", cur_test, test_errs);
    end
  endtask

  // one strobe on the data port, then wait for its response
  task automatic data_access(input logic wr, input fetch_pkg::addr_t addr,
                             input fetch_pkg::word_t wdata, output fetch_pkg::word_t rdata);
    int cycles;
    @(posedge clk);
    #1;
    data_req.valid = 1'b1;
    data_req.write = wr;
    data_req.addr  = addr;
    data_req.wdata = wdata;
    @(posedge clk);
    #1;
    data_req = '0;
    cycles = 1;
    while (!data_rsp.valid && cycles < timeout_cycles)
    begin
      @(posedge clk);
      #1;
      cycles++;
    end
    rdata = data_rsp.rdata;
    if (!data_rsp.valid)
    begin
      $display("%s: no data response within %0d cycles for address %h",
               cur_test, timeout_cycles, addr);
      test_errs++;
    end
  endtask

  task automatic data_write(input fetch_pkg::addr_t addr, input fetch_pkg::word_t wdata);
    fetch_pkg::word_t rd;
    img[img_index(addr)] = wdata;
    data_access(1'b1, addr, wdata, rd);
    check_word("write ack rdata", '0, rd);
  endtask

  task automatic data_read(input fetch_pkg::addr_t addr, output fetch_pkg::word_t rdata);
    data_access(1'b0, addr, '0, rdata);
  endtask

  // predicts hit or refill from the model, then fetches and checks
  task automatic fetch(input fetch_pkg::addr_t pc);
    fetch_pkg::ic_index_t    idx;
    fetch_pkg::ic_tag_t      tag;
    logic [`IC_OFFSET_W-1:0] off;
    fetch_pkg::addr_t        base;
    fetch_pkg::word_t        exp_inst;
    logic                    exp_hit;
    int                      cycles;
    idx = pc[tag_lsb-1:`IC_OFFSET_W+2];
    tag = pc[`FETCH_ADDR_W-1:tag_lsb];
    off = pc[`IC_OFFSET_W+1:2];
    base = {tag, idx, {`IC_OFFSET_W{1'b0}}, 2'b00};
    exp_hit = mdl_valid[idx] && (mdl_tag[idx] == tag);
    if (!exp_hit)
    begin
      for (int w = 0; w < `IC_LINE_WORDS; w++)
      begin
        mdl_line[idx][w] = img[img_index(base + w * 4)];
      end
      mdl_tag[idx]   = tag;
      mdl_valid[idx] = 1'b1;
    end
    exp_inst = mdl_line[idx][off];
    if (exp_inst == `FENCE_I_WORD)
    begin
      mdl_valid = '0;
    end
    @(posedge clk);
    #1;
    fetch_req.valid = 1'b1;
    fetch_req.pc    = pc;
    @(posedge clk);
    #1;
    fetch_req = '0;
    cycles = 1;
    while (!fetch_rsp.valid && cycles < timeout_cycles)
    begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (fetch_rsp.valid)
    begin
      check_word("inst", exp_inst, fetch_rsp.inst);
      check_addr("pc", pc, fetch_rsp.pc);
      if (exp_hit)
      begin
        check_cycles("hit latency", 1, cycles);
      end
    end
    else
    begin
      $display("%s: no fetch response within %0d cycles for pc %h",
               cur_test, timeout_cycles, pc);
      test_errs++;
    end
  endtask

  task automatic test_data_round_trip();
    fetch_pkg::addr_t addrs [4];
    fetch_pkg::word_t rd;
    start_test("data_round_trip");
    addrs = '{32'h200, 32'h204, 32'h3f0, 32'hffc};
    foreach (addrs[i])
    begin
      data_write(addrs[i], lcg_next());
    end
    foreach (addrs[i])
    begin
      data_read(addrs[i], rd);
      check_word("read back", img[img_index(addrs[i])], rd);
    end
    end_test();
  endtask

  task automatic test_miss_then_hit();
    start_test("miss_then_hit");
    data_write(pc_a, rand_inst());
    data_write(pc_a ^ 32'h4, rand_inst());
    fetch(pc_a);
    fetch(pc_a);
    // neighbor came in with the same refill
    fetch(pc_a ^ 32'h4);
    end_test();
  endtask

  task automatic test_stale_inst();
    start_test("stale_inst");
    data_write(pc_a, rand_inst());
    fetch(pc_a);
    end_test();
  endtask

  task automatic test_fence_invalidate();
    start_test("fence_invalidate");
    data_write(pc_fence, `FENCE_I_WORD);
    data_write(pc_fence ^ 32'h4, rand_inst());
    fetch(pc_fence);
    fetch(pc_a);
    end_test();
  endtask

  task automatic test_conflict_evict();
    start_test("conflict_evict");
    data_write(pc_b, rand_inst());
    data_write(pc_b ^ 32'h4, rand_inst());
    data_write(pc_c, rand_inst());
    data_write(pc_c ^ 32'h4, rand_inst());
    fetch(pc_b);
    fetch(pc_c);
    fetch(pc_b);
    fetch(pc_c);
    end_test();
  endtask

  task automatic test_arbitration();
    fetch_pkg::word_t rd;
    start_test("arbitration");
    data_write(pc_e, rand_inst());
    data_write(pc_e ^ 32'h4, rand_inst());
    // both requests land in the same cycle
    fork
      data_write(data_d, lcg_next());
      fetch(pc_e);
    join
    data_read(data_d, rd);
    check_word("data after race", img[img_index(data_d)], rd);
    end_test();
  endtask

  initial
  begin
    clk          = 1'b0;
    rst          = 1'b1;
    fetch_req    = '0;
    data_req     = '0;
    lcg_state    = 32'd27602;
    mdl_valid    = '0;
    test_errs    = 0;
    total_errs   = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    test_data_round_trip();
    test_miss_then_hit();
    test_stale_inst();
    test_fence_invalidate();
    test_conflict_evict();
    test_arbitration();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
    if (total_errs == 0)
    begin
      $display("TESTS PASSED");
    end
    else
    begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
